// File: Makefile
SIM      := verilator
FLAGS    := --timing --assert
TOP      := tb_uart_rx_monitor
FILELIST := list.f
LOG      := sim.log
OBJ      := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ)/V$(TOP): $(shell cat $(FILELIST))
	$(SIM) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o V$(TOP)

sim: $(OBJ)/V$(TOP)
	./$(OBJ)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

// File: bench/rx_checker.sv
module rx_checker import uart_mon_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Read data channel
  input  logic              rvalid,
  input  logic              rready,
  input  logic [DATA_W-1:0] rdata,
  input  logic [1:0]        rresp,
  // Write response channel
  input  logic              bvalid,
  input  logic              bready,
  input  logic [1:0]        bresp,
  // Expected values from the stimulus loop
  input  logic              exp_check,
  input  logic [DATA_W-1:0] exp_rdata,
  input  logic [1:0]        exp_resp,
  input  logic              timeout_pulse,
  output int                mismatches,
  output int                timeouts
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    mismatches = 0;
    timeouts   = 0;
  end

  // ----------------------------------------------------------
  // Compare on each completed handshake
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && rvalid && rready && exp_check) begin
      if (rdata !== exp_rdata) begin
        $display("MISMATCH at %0t: rdata got %h expected %h", $time, rdata, exp_rdata);
        mismatches++;
      end
      if (rresp !== exp_resp) begin
        $display("MISMATCH at %0t: rresp got %b expected %b", $time, rresp, exp_resp);
        mismatches++;
      end
    end
    if (rst_n && bvalid && bready && exp_check) begin
      if (bresp !== exp_resp) begin
        $display("MISMATCH at %0t: bresp got %b expected %b", $time, bresp, exp_resp);
        mismatches++;
      end
    end
    if (timeout_pulse) begin
      timeouts++;
    end
  end

endmodule

// File: bench/tb_uart_rx_monitor.sv
module tb_uart_rx_monitor import uart_mon_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ACT_FRAME = 0;
  localparam int ACT_BAD   = 1;
  localparam int ACT_GLITCH = 2;
  localparam int ACT_WAIT  = 3;
  localparam int ACT_WRITE = 4;
  localparam int ACT_READ  = 5;
  localparam int BUS_LIMIT = 20;
  localparam int POLL_LIMIT = 60;

  typedef struct {
    int                act;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        val;
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] exp;
    logic [1:0]        resp;
  } step_t;

  logic              clk;
  logic              rst_n;
  logic              rx;
  logic [ADDR_W-1:0] awaddr;
  logic              awvalid;
  logic              awready;
  logic [DATA_W-1:0] wdata;
  logic [STRB_W-1:0] wstrb;
  logic              wvalid;
  logic              wready;
  logic [1:0]        bresp;
  logic              bvalid;
  logic              bready;
  logic [ADDR_W-1:0] araddr;
  logic              arvalid;
  logic              arready;
  logic [DATA_W-1:0] rdata;
  logic [1:0]        rresp;
  logic              rvalid;
  logic              rready;

  // Expected values handed to the checker
  logic              exp_check;
  logic [DATA_W-1:0] exp_rdata;
  logic [1:0]        exp_resp;
  logic              timeout_pulse;
  int                mismatches;
  int                timeouts;

  step_t             steps[$];
  integer            seed;

  uart_rx_monitor DUT (.*);

  rx_checker u_checker (
    .clk           (clk),
    .rst_n         (rst_n),
    .rvalid        (rvalid),
    .rready        (rready),
    .rdata         (rdata),
    .rresp         (rresp),
    .bvalid        (bvalid),
    .bready        (bready),
    .bresp         (bresp),
    .exp_check     (exp_check),
    .exp_rdata     (exp_rdata),
    .exp_resp      (exp_resp),
    .timeout_pulse (timeout_pulse),
    .mismatches    (mismatches),
    .timeouts      (timeouts)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Bus and serial line tasks
  // ----------------------------------------------------------
  task automatic report_timeout(input string what);
    $display("Timeout at %0t: no %s from the DUT", $time, what);
    timeout_pulse <= 1'b1;
    @(posedge clk);
    timeout_pulse <= 1'b0;
  endtask

  task automatic write_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                           input logic [1:0] resp);
    int n;
    @(posedge clk);
    exp_check <= 1'b1;
    exp_resp  <= resp;
    awaddr    <= addr;
    wdata     <= data;
    awvalid   <= 1'b1;
    wvalid    <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < BUS_LIMIT);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (!(awready && wready)) begin
      report_timeout("awready and wready");
    end else begin
      // Response is left pending until it is seen
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!bvalid && n < BUS_LIMIT);
      if (!bvalid) begin
        report_timeout("bvalid");
      end else begin
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
      end
    end
    exp_check <= 1'b0;
  endtask

  task automatic read_reg(input logic [ADDR_W-1:0] addr, input logic check,
                          input logic [DATA_W-1:0] exp, input logic [1:0] resp,
                          output logic [DATA_W-1:0] data);
    int n;
    data = '0;
    @(posedge clk);
    exp_check <= check;
    exp_rdata <= exp;
    exp_resp  <= resp;
    araddr    <= addr;
    arvalid   <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < BUS_LIMIT);
    arvalid <= 1'b0;
    if (!arready) begin
      report_timeout("arready");
    end else begin
      // Response is left pending until it is seen
      n = 0;
      do begin
        @(posedge clk);
        n++;
      end while (!rvalid && n < BUS_LIMIT);
      if (!rvalid) begin
        report_timeout("rvalid");
      end else begin
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
        data = rdata;
      end
    end
    exp_check <= 1'b0;
  endtask

  task automatic hold_line(input logic level, input int cycles);
    rx <= level;
    repeat (cycles) @(posedge clk);
  endtask

  // Start bit, LSB first data, stop bit, then one idle bit
  task automatic send_frame(input logic [7:0] val, input logic good_stop);
    @(posedge clk);
    hold_line(1'b0, BIT_TICKS);
    for (int i = 0; i < DATA_BITS; i++) begin
      hold_line(val[i], BIT_TICKS);
    end
    hold_line(good_stop, BIT_TICKS);
    hold_line(1'b1, BIT_TICKS);
  endtask

  task automatic wait_for_data();
    logic [DATA_W-1:0] st;
    int                n;
    n = 0;
    do begin
      read_reg(STATUS_OFF, 1'b0, '0, RESP_OKAY, st);
      n++;
    end while (!st[0] && n < POLL_LIMIT);
    if (!st[0]) report_timeout("data available flag");
  endtask

  function automatic void add(input int act, input logic [ADDR_W-1:0] addr,
                              input logic [7:0] val, input logic [DATA_W-1:0] wdat,
                              input logic [DATA_W-1:0] exp, input logic [1:0] resp);
    step_t s;
    s.act  = act;
    s.addr = addr;
    s.val  = val;
    s.wdat = wdat;
    s.exp  = exp;
    s.resp = resp;
    steps.push_back(s);
  endfunction

  // ----------------------------------------------------------
  // Stimulus table
  // ----------------------------------------------------------
  task automatic build_steps();
    logic [7:0] b[5];
    logic [7:0] bad;
    add(ACT_READ, CTRL_OFF, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, STATUS_OFF, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, ERRCNT_OFF, 0, 0, 0, RESP_OKAY);
    // Reception disabled, then a short glitch once enabled
    add(ACT_FRAME, 0, 8'h5A, 0, 0, RESP_OKAY);
    add(ACT_READ, STATUS_OFF, 0, 0, 0, RESP_OKAY);
    add(ACT_WRITE, CTRL_OFF, 0, 1, 0, RESP_OKAY);
    add(ACT_GLITCH, 0, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, STATUS_OFF, 0, 0, 0, RESP_OKAY);
    // Three frames read back in order
    for (int i = 0; i < 3; i++) begin
      b[i] = 8'($random(seed));
      add(ACT_FRAME, 0, b[i], 0, 0, RESP_OKAY);
    end
    add(ACT_WAIT, 0, 0, 0, 0, RESP_OKAY);
    for (int i = 0; i < 3; i++) begin
      add(ACT_READ, RXDATA_OFF, 0, 0, {24'h0, b[i]}, RESP_OKAY);
    end
    add(ACT_READ, STATUS_OFF, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, RXDATA_OFF, 0, 0, 0, RESP_OKAY);
    // Bad stop bit
    bad = 8'($random(seed));
    add(ACT_BAD, 0, bad, 0, 0, RESP_OKAY);
    add(ACT_WAIT, 0, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, RXDATA_OFF, 0, 0, {23'h0, 1'b1, bad}, RESP_OKAY);
    add(ACT_READ, ERRCNT_OFF, 0, 0, 1, RESP_OKAY);
    add(ACT_WRITE, ERRCNT_OFF, 0, 0, 0, RESP_OKAY);
    add(ACT_READ, ERRCNT_OFF, 0, 0, 0, RESP_OKAY);
    // Overflow, the fifth byte is dropped
    for (int i = 0; i < 5; i++) begin
      b[i] = 8'($random(seed));
      add(ACT_FRAME, 0, b[i], 0, 0, RESP_OKAY);
    end
    add(ACT_READ, STATUS_OFF, 0, 0, 3, RESP_OKAY);
    for (int i = 0; i < 4; i++) begin
      add(ACT_READ, RXDATA_OFF, 0, 0, {24'h0, b[i]}, RESP_OKAY);
    end
    add(ACT_READ, STATUS_OFF, 0, 0, 2, RESP_OKAY);
    add(ACT_WRITE, CTRL_OFF, 0, 1, 0, RESP_OKAY);
    add(ACT_READ, STATUS_OFF, 0, 0, 0, RESP_OKAY);
    // Unmapped read and read-only write
    add(ACT_READ, 4'hE, 0, 0, 0, RESP_SLVERR);
    add(ACT_WRITE, STATUS_OFF, 0, 1, 0, RESP_SLVERR);
  endtask

  initial begin
    logic [DATA_W-1:0] data;
    seed          = 32'h8d34_bbe4;
    rst_n         = 1'b0;
    rx            = 1'b1;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = '1;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    exp_check     = 1'b0;
    exp_rdata     = '0;
    exp_resp      = '0;
    timeout_pulse = 1'b0;
    build_steps();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);

    foreach (steps[i]) begin
      case (steps[i].act)
        ACT_FRAME: send_frame(steps[i].val, 1'b1);
        ACT_BAD:   send_frame(steps[i].val, 1'b0);
        ACT_GLITCH: begin
          @(posedge clk);
          hold_line(1'b0, HALF_TICKS / 4);
          hold_line(1'b1, 2 * BIT_TICKS);
        end
        ACT_WAIT:  wait_for_data();
        ACT_WRITE: write_reg(steps[i].addr, steps[i].wdat, steps[i].resp);
        default:   read_reg(steps[i].addr, 1'b1, steps[i].exp, steps[i].resp, data);
      endcase
    end

    repeat (4) @(posedge clk);
    $display("Checks done: %0d mismatches, %0d timeouts, %0d assertion failures",
             mismatches, timeouts, DUT.u_regs.u_props.fail_count);
    if (mismatches == 0 && timeouts == 0 && DUT.u_regs.u_props.fail_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: bench/uart_rx_monitor_props.sv
module uart_rx_monitor_props import uart_mon_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic              bvalid,
  input logic              bready,
  input logic              rvalid,
  input logic              rready,
  input logic [DATA_W-1:0] rdata
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  property hold_until_ready(logic v, logic r);
    @(posedge clk) disable iff (!rst_n) v && !r |=> v;
  endproperty

  a_bvalid_hold: assert property (hold_until_ready(bvalid, bready))
    else begin
      $error("bvalid dropped before bready");
      fail_count++;
    end
  a_rvalid_hold: assert property (hold_until_ready(rvalid, rready))
    else begin
      $error("rvalid dropped before rready");
      fail_count++;
    end
  a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> $stable(rdata))
    else begin
      $error("rdata changed while waiting for rready");
      fail_count++;
    end
  // One response in flight per channel
  a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && bready |=> !bvalid)
    else begin
      $error("new write response started while one was pending");
      fail_count++;
    end
  a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && rready |=> !rvalid)
    else begin
      $error("new read response started while one was pending");
      fail_count++;
    end

endmodule

bind axil_rx_regs uart_rx_monitor_props u_props (.*);

// File: design/axil_rx_regs.sv
module axil_rx_regs import uart_mon_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Write address and data
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  // Write response
  output axi_resp_e         bresp,
  output logic              bvalid,
  input  logic              bready,
  // Read address
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  // Read data
  output logic [DATA_W-1:0] rdata,
  output axi_resp_e         rresp,
  output logic              rvalid,
  input  logic              rready,
  // Queue and sampler side
  input  logic [DATA_BITS:0] head,
  input  logic              not_empty,
  input  logic              overflow,
  input  logic              frame_err_seen,
  output logic              pop,
  output logic              rx_enable
);

  logic                wr_accept;
  logic                rd_accept;
  logic                ctrl_wr;
  logic                errcnt_wr;
  axi_resp_e           wr_resp;
  axi_resp_e           rd_resp;
  logic [DATA_W-1:0]   rd_data;
  logic                ovf_flag;
  logic [ERRCNT_W-1:0] errcnt;

  // ----------------------------------------------------------
  // Handshakes
  // ----------------------------------------------------------
  // Address and data are taken together, one write in flight
  assign wr_accept = awvalid & wvalid & ~bvalid;
  assign awready   = wr_accept;
  assign wready    = wr_accept;

  assign arready   = ~rvalid;
  assign rd_accept = arvalid & arready;

  assign ctrl_wr   = wr_accept && (awaddr == CTRL_OFF);
  assign errcnt_wr = wr_accept && (awaddr == ERRCNT_OFF);

  // Empty queue reads return zero and leave the pointers alone
  assign pop = rd_accept && (araddr == RXDATA_OFF) && not_empty;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  always_comb begin
    case (awaddr)
      CTRL_OFF, ERRCNT_OFF: wr_resp = RESP_OKAY;
      default:              wr_resp = RESP_SLVERR;
    endcase
  end

  always_comb begin
    rd_data = '0;
    rd_resp = RESP_OKAY;
    case (araddr)
      CTRL_OFF:   rd_data = {{(DATA_W-1){1'b0}}, rx_enable};
      STATUS_OFF: rd_data = {{(DATA_W-2){1'b0}}, ovf_flag, not_empty};
      RXDATA_OFF: begin
        if (not_empty) begin
          rd_data = {{(DATA_W-DATA_BITS-1){1'b0}}, head};
        end
      end
      ERRCNT_OFF: rd_data = {{(DATA_W-ERRCNT_W){1'b0}}, errcnt};
      default:    rd_resp = RESP_SLVERR;
    endcase
  end

  // ----------------------------------------------------------
  // Registers and response state
  // ----------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      rx_enable <= 1'b0;
      ovf_flag  <= 1'b0;
      errcnt    <= '0;
    end else begin
      if (wr_accept) begin
        bvalid <= 1'b1;
      end else if (bready) begin
        bvalid <= 1'b0;
      end

      if (rd_accept) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end

      if (ctrl_wr && wstrb[0]) begin
        rx_enable <= wdata[0];
      end

      // A new overflow wins over a clearing write in the same cycle
      if (overflow) begin
        ovf_flag <= 1'b1;
      end else if (ctrl_wr) begin
        ovf_flag <= 1'b0;
      end

      // Saturating frame error count
      if (errcnt_wr) begin
        errcnt <= ERRCNT_W'(frame_err_seen);
      end else if (frame_err_seen && errcnt != '1) begin
        errcnt <= errcnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp <= wr_resp;
    end
    if (rd_accept) begin
      rdata <= rd_data;
      rresp <= rd_resp;
    end
  end

endmodule

// File: design/rx_byte_if.sv
interface rx_byte_if import uart_mon_pkg::*; ();

  // One-cycle pulse offering a received byte
  logic                 valid;
  logic [DATA_BITS-1:0] data;
  // Stop bit was sampled low
  logic                 frame_err;
  // Queue cannot take another byte
  logic                 full;

  modport sampler (
    output valid,
    output data,
    output frame_err,
    input  full
  );

  modport queue (
    input  valid,
    input  data,
    input  frame_err,
    output full
  );

endinterface

// File: design/rx_byte_queue.sv
module rx_byte_queue import uart_mon_pkg::*; (
  input  logic               clk,
  input  logic               rst_n,
  rx_byte_if.queue           in,
  input  logic               pop,
  output logic [DATA_BITS:0] head,
  output logic               not_empty,
  output logic               overflow
);

  logic [DATA_BITS:0] mem [QUEUE_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  logic [PTR_W:0]     count;
  logic               push;

  assign in.full   = (count == (PTR_W+1)'(QUEUE_DEPTH));
  assign push      = in.valid & ~in.full;
  assign overflow  = in.valid & in.full;
  assign not_empty = (count != '0);
  assign head      = mem[rd_ptr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in.frame_err, in.data};
    end
  end

endmodule

// File: design/uart_line_sampler.sv
module uart_line_sampler import uart_mon_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rx,
  input  logic          rx_enable,
  rx_byte_if.sampler    out
);

  // ----------------------------------------------------------
  // Line synchronizer and falling edge detect
  // ----------------------------------------------------------
  // Stages 0 and 1 synchronize, stage 2 holds the previous level
  logic [2:0] rx_pipe;
  logic       rx_s;
  logic       start_edge;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_pipe <= '1;
    end else begin
      rx_pipe <= {rx_pipe[1:0], rx};
    end
  end

  assign rx_s       = rx_pipe[1];
  assign start_edge = rx_pipe[2] & ~rx_s;

  // ----------------------------------------------------------
  // Frame timing FSM
  // ----------------------------------------------------------
  rx_state_e            state;
  logic [TICK_W-1:0]    tick;
  logic [BIT_IDX_W-1:0] bit_idx;
  logic                 bit_centre;
  logic                 half_point;
  logic                 valid_q;
  logic                 frame_err_q;
  logic [DATA_BITS-1:0] shift_q;

  assign bit_centre = (tick == TICK_W'(BIT_TICKS - 1));
  assign half_point = (tick == TICK_W'(HALF_TICKS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= RX_IDLE;
      tick        <= '0;
      bit_idx     <= '0;
      valid_q     <= 1'b0;
      frame_err_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          tick    <= '0;
          bit_idx <= '0;
          // Start detection only while reception is enabled
          if (rx_enable && start_edge) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (half_point) begin
            tick  <= '0;
            // A high line here is a glitch, not a start bit
            state <= rx_s ? RX_IDLE : RX_DATA;
          end else begin
            tick <= tick + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_centre) begin
            tick    <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == BIT_IDX_W'(DATA_BITS - 1)) begin
              state <= RX_STOP;
            end
          end else begin
            tick <= tick + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_centre) begin
            tick        <= '0;
            state       <= RX_IDLE;
            valid_q     <= 1'b1;
            frame_err_q <= ~rx_s;
          end else begin
            tick <= tick + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // LSB arrives first, so shift in from the top
  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_centre) begin
      shift_q <= {rx_s, shift_q[DATA_BITS-1:1]};
    end
  end

  assign out.valid     = valid_q;
  assign out.data      = shift_q;
  assign out.frame_err = frame_err_q;

endmodule

// File: design/uart_mon_pkg.sv
package uart_mon_pkg;

  // ----------------------------------------------------------
  // Serial bit timing
  // ----------------------------------------------------------
  // Clock cycles per serial bit
  localparam int BIT_TICKS  = 87;
  // Start bit is checked again at this point
  localparam int HALF_TICKS = BIT_TICKS / 2;
  localparam int DATA_BITS  = 8;
  localparam int TICK_W     = $clog2(BIT_TICKS);
  localparam int BIT_IDX_W  = $clog2(DATA_BITS);

  // ----------------------------------------------------------
  // Byte queue
  // ----------------------------------------------------------
  localparam int QUEUE_DEPTH = 4;
  localparam int PTR_W       = $clog2(QUEUE_DEPTH);

  // ----------------------------------------------------------
  // Register block
  // ----------------------------------------------------------
  localparam int ADDR_W   = 4;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;
  localparam int ERRCNT_W = 16;

  // Bit 0 enables reception
  localparam logic [ADDR_W-1:0] CTRL_OFF   = 4'h0;
  // Bit 0 data available, bit 1 sticky overflow
  localparam logic [ADDR_W-1:0] STATUS_OFF = 4'h4;
  // Read pops the queue; bit 8 is the frame error
  localparam logic [ADDR_W-1:0] RXDATA_OFF = 4'h8;
  localparam logic [ADDR_W-1:0] ERRCNT_OFF = 4'hC;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_e;

endpackage

// File: design/uart_rx_monitor.sv
module uart_rx_monitor import uart_mon_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // Serial line
  input  logic              rx,
  // AXI4-Lite slave
  input  logic [ADDR_W-1:0] awaddr,
  input  logic              awvalid,
  output logic              awready,
  input  logic [DATA_W-1:0] wdata,
  input  logic [STRB_W-1:0] wstrb,
  input  logic              wvalid,
  output logic              wready,
  output logic [1:0]        bresp,
  output logic              bvalid,
  input  logic              bready,
  input  logic [ADDR_W-1:0] araddr,
  input  logic              arvalid,
  output logic              arready,
  output logic [DATA_W-1:0] rdata,
  output logic [1:0]        rresp,
  output logic              rvalid,
  input  logic              rready
);

  logic               rx_enable;
  logic               pop;
  logic [DATA_BITS:0] head;
  logic               not_empty;
  logic               overflow;
  logic               frame_err_seen;

  rx_byte_if u_byte_if ();

  // Count every offered frame with a bad stop bit, even if dropped
  assign frame_err_seen = u_byte_if.valid & u_byte_if.frame_err;

  uart_line_sampler u_sampler (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .rx_enable (rx_enable),
    .out       (u_byte_if.sampler)
  );

  rx_byte_queue u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .in        (u_byte_if.queue),
    .pop       (pop),
    .head      (head),
    .not_empty (not_empty),
    .overflow  (overflow)
  );

  axil_rx_regs u_regs (
    .clk            (clk),
    .rst_n          (rst_n),
    .awaddr         (awaddr),
    .awvalid        (awvalid),
    .awready        (awready),
    .wdata          (wdata),
    .wstrb          (wstrb),
    .wvalid         (wvalid),
    .wready         (wready),
    .bresp          (bresp),
    .bvalid         (bvalid),
    .bready         (bready),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arready        (arready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rready         (rready),
    .head           (head),
    .not_empty      (not_empty),
    .overflow       (overflow),
    .frame_err_seen (frame_err_seen),
    .pop            (pop),
    .rx_enable      (rx_enable)
  );

endmodule

// File: list.f
design/uart_mon_pkg.sv
design/rx_byte_if.sv
design/uart_line_sampler.sv
design/rx_byte_queue.sv
design/axil_rx_regs.sv
design/uart_rx_monitor.sv
bench/rx_checker.sv
bench/uart_rx_monitor_props.sv
bench/tb_uart_rx_monitor.sv
